// File: src/led_panel_config.svh
/*
 * panel geometry and framebuffer sizing macros
 */
`ifndef LED_PANEL_CONFIG_SVH
`define LED_PANEL_CONFIG_SVH

// columns across the panel
`define LED_PANEL_WIDTH 64

// rows in each half, both halves are scanned together
`define LED_PANEL_HALF_HEIGHT 16

// rgb565 pixels
`define LED_BYTES_PER_PIXEL 2

// row in the upper bits, column in the lower bits
`define LED_FB_ADDR_BITS 10

`endif

// File: src/panel_types_pkg.sv
/*
 * pixel and coordinate types, framebuffer word views
 */
`include "led_panel_config.svh"

package panel_types_pkg;

    typedef logic [$clog2(`LED_PANEL_WIDTH)-1:0] col_addr_t;
    typedef logic [$clog2(`LED_PANEL_HALF_HEIGHT)-1:0] row_addr_t;

    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // bottom half pixel sits in the upper halfword
    typedef struct packed {
        rgb565_t bottom;
        rgb565_t top;
    } pixel_pair_t;

    typedef union packed {
        logic [2*8*`LED_BYTES_PER_PIXEL-1:0] raw;
        pixel_pair_t pair;
    } fb_word_u;

endpackage

// File: src/bus_types_pkg.sv
/*
 * framebuffer memory bus types and arbiter owner encoding
 */
`include "led_panel_config.svh"

package bus_types_pkg;

    typedef logic [`LED_FB_ADDR_BITS-1:0] fb_addr_t;

    // one word carries the top and bottom pixel of a column
    typedef logic [2*8*`LED_BYTES_PER_PIXEL-1:0] fb_data_t;

    // which master was accepted in the previous cycle
    typedef enum logic [1:0] {
        owner_none,
        owner_fetch,
        owner_host
    } owner_e;

endpackage

// File: src/framebuffer_ram.sv
/*
 * single-port synchronous framebuffer RAM with registered read
 */
`timescale 1ns/1ps

module framebuffer_ram #(
    parameter int unsigned depth = 1 << $bits(bus_types_pkg::fb_addr_t)
) (
    input  logic                   clk_in,
    input  logic                   en,
    input  logic                   we,
    input  bus_types_pkg::fb_addr_t addr,
    input  bus_types_pkg::fb_data_t wdata,
    output bus_types_pkg::fb_data_t rdata
);

    bus_types_pkg::fb_data_t mem [depth];

    // write leaves the read register alone
    always_ff @(posedge clk_in) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

// File: src/fb_arbiter.sv
/*
 * fixed-priority arbiter, fetch master and host Wishbone slave onto one RAM
 */
`timescale 1ns/1ps

module fb_arbiter (
    input  logic                    clk_in,
    input  logic                    reset,
    input  logic                    fetch_cyc,
    input  logic                    fetch_stb,
    input  bus_types_pkg::fb_addr_t fetch_adr,
    output logic                    fetch_ack,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  bus_types_pkg::fb_addr_t wb_adr,
    input  bus_types_pkg::fb_data_t wb_dat_w,
    output logic                    wb_ack,
    output bus_types_pkg::fb_data_t rd_data,
    output logic                    ram_en,
    output logic                    ram_we,
    output bus_types_pkg::fb_addr_t ram_addr,
    output bus_types_pkg::fb_data_t ram_wdata,
    input  bus_types_pkg::fb_data_t ram_rdata
);

    bus_types_pkg::owner_e owner;
    logic fetch_req;
    logic host_req;
    logic grant_fetch;
    logic grant_host;

    // a master still holds stb in its ack cycle, so it is masked there
    assign fetch_req = fetch_cyc && fetch_stb && (owner != bus_types_pkg::owner_fetch);
    assign host_req = wb_cyc && wb_stb && (owner != bus_types_pkg::owner_host);

    // fetch first
    assign grant_fetch = fetch_req;
    assign grant_host = host_req && !fetch_req;

    assign ram_en = grant_fetch || grant_host;
    assign ram_we = grant_host && wb_we;
    assign ram_addr = grant_fetch ? fetch_adr : wb_adr;
    assign ram_wdata = wb_dat_w;

    // RAM output is shared by both readers
    assign rd_data = ram_rdata;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            owner <= bus_types_pkg::owner_none;
        end else if (grant_fetch) begin
            owner <= bus_types_pkg::owner_fetch;
        end else if (grant_host) begin
            owner <= bus_types_pkg::owner_host;
        end else begin
            owner <= bus_types_pkg::owner_none;
        end
    end

    assign fetch_ack = (owner == bus_types_pkg::owner_fetch);
    assign wb_ack = (owner == bus_types_pkg::owner_host);

    // a pending fetch keeps its request and address up to the ack
    fetch_held_until_ack: assert property (@(posedge clk_in) disable iff (reset)
        fetch_cyc && fetch_stb && !fetch_ack |=>
            fetch_cyc && fetch_stb && $stable(fetch_adr));

    // a waiting host keeps its request, address and direction until served
    host_held_until_ack: assert property (@(posedge clk_in) disable iff (reset)
        wb_cyc && wb_stb && !wb_ack |=>
            wb_ack || (wb_cyc && wb_stb && $stable(wb_adr) && $stable(wb_we)));

endmodule

// File: src/framebuffer_fetch.sv
/*
 * framebuffer fetch unit, column and row to RAM read, top and bottom pixel latch
 */
`timescale 1ns/1ps

module framebuffer_fetch (
    input  logic                       clk_in,
    input  logic                       reset,
    input  panel_types_pkg::col_addr_t col,
    input  panel_types_pkg::row_addr_t row,
    input  logic                       load_start,
    output logic                       fetch_cyc,
    output logic                       fetch_stb,
    output bus_types_pkg::fb_addr_t    fetch_adr,
    input  logic                       fetch_ack,
    input  bus_types_pkg::fb_data_t    rd_data,
    output panel_types_pkg::rgb565_t   pixel_top,
    output panel_types_pkg::rgb565_t   pixel_bottom,
    output logic                       load_done
);

    logic busy;
    bus_types_pkg::fb_addr_t adr_q;
    panel_types_pkg::fb_word_u word;

    assign word.raw = rd_data;

    // request stays up until the arbiter acks it
    always_ff @(posedge clk_in) begin
        if (reset) begin
            busy <= 1'b0;
            load_done <= 1'b0;
        end else begin
            load_done <= busy && fetch_ack;
            if (load_start) begin
                busy <= 1'b1;
            end else if (fetch_ack) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (load_start) begin
            adr_q <= {row, col};
        end
        if (busy && fetch_ack) begin
            pixel_top <= word.pair.top;
            pixel_bottom <= word.pair.bottom;
        end
    end

    assign fetch_cyc = busy;
    assign fetch_stb = busy;
    assign fetch_adr = adr_q;

    // scanner waits for load_done before the next column
    no_overlapping_load: assert property (@(posedge clk_in) disable iff (reset)
        load_start |-> !busy);

endmodule

// File: src/row_scanner.sv
/*
 * HUB75 column and row sequencer
 * drives panel clock, latch, blanking and one colour bit per channel
 */
`timescale 1ns/1ps

module row_scanner (
    input  logic                       clk_in,
    input  logic                       reset,
    output panel_types_pkg::col_addr_t col,
    output panel_types_pkg::row_addr_t row_sel,
    output logic                       load_start,
    input  logic                       load_done,
    input  panel_types_pkg::rgb565_t   pixel_top,
    input  panel_types_pkg::rgb565_t   pixel_bottom,
    output logic [2:0]                 rgb_top,
    output logic [2:0]                 rgb_bottom,
    output logic                       panel_clk,
    output logic                       latch,
    output logic                       blank
);

    typedef enum logic [1:0] {
        st_fetch,
        st_present,
        st_clock,
        st_row_end
    } state_t;

    state_t state;
    logic [1:0] blank_cnt;

    // msb of each field, red in bit 2
    function automatic logic [2:0] msb_rgb(input panel_types_pkg::rgb565_t px);
        return {px.red[4], px.green[5], px.blue[4]};
    endfunction

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= st_fetch;
            col <= '0;
            row_sel <= '0;
            // first column request leaves reset pending
            load_start <= 1'b1;
            rgb_top <= 3'b000;
            rgb_bottom <= 3'b000;
            panel_clk <= 1'b0;
            latch <= 1'b0;
            blank <= 1'b1;
            blank_cnt <= 2'd0;
        end else begin
            load_start <= 1'b0;
            case (state)
                st_fetch: begin
                    if (load_done) begin
                        rgb_top <= msb_rgb(pixel_top);
                        rgb_bottom <= msb_rgb(pixel_bottom);
                        state <= st_present;
                    end
                end
                st_present: begin
                    panel_clk <= 1'b1;
                    state <= st_clock;
                end
                st_clock: begin
                    panel_clk <= 1'b0;
                    if (col == '1) begin
                        blank <= 1'b1;
                        blank_cnt <= 2'd0;
                        state <= st_row_end;
                    end else begin
                        col <= col + 1'b1;
                        load_start <= 1'b1;
                        state <= st_fetch;
                    end
                end
                st_row_end: begin
                    // four blanked cycles, latch in the second, new row in the third
                    blank_cnt <= blank_cnt + 1'b1;
                    latch <= (blank_cnt == 2'd0);
                    if (blank_cnt == 2'd1) begin
                        row_sel <= row_sel + 1'b1;
                    end
                    if (blank_cnt == 2'd3) begin
                        blank <= 1'b0;
                        col <= '0;
                        load_start <= 1'b1;
                        state <= st_fetch;
                    end
                end
                default: state <= st_fetch;
            endcase
        end
    end

endmodule

// File: src/led_panel_top.sv
/*
 * LED panel top level, host port, arbiter, RAM, fetch unit and scanner
 */
`timescale 1ns/1ps
`include "led_panel_config.svh"

module led_panel_top (
    input  logic                       clk_in,
    input  logic                       reset,
    input  logic                       wb_cyc,
    input  logic                       wb_stb,
    input  logic                       wb_we,
    input  bus_types_pkg::fb_addr_t    wb_adr,
    input  bus_types_pkg::fb_data_t    wb_dat_w,
    output bus_types_pkg::fb_data_t    wb_dat_r,
    output logic                       wb_ack,
    output logic [2:0]                 rgb_top,
    output logic [2:0]                 rgb_bottom,
    output logic                       panel_clk,
    output logic                       latch,
    output logic                       blank,
    output panel_types_pkg::row_addr_t row_sel
);

    logic fetch_cyc;
    logic fetch_stb;
    logic fetch_ack;
    bus_types_pkg::fb_addr_t fetch_adr;
    logic ram_en;
    logic ram_we;
    bus_types_pkg::fb_addr_t ram_addr;
    bus_types_pkg::fb_data_t ram_wdata;
    bus_types_pkg::fb_data_t ram_rdata;
    panel_types_pkg::col_addr_t col;
    logic load_start;
    logic load_done;
    panel_types_pkg::rgb565_t pixel_top;
    panel_types_pkg::rgb565_t pixel_bottom;

    // wb_dat_r doubles as the shared read path into the fetch unit
    fb_arbiter fb_arbiter_inst (
        .clk_in(clk_in), .reset(reset),
        .fetch_cyc(fetch_cyc), .fetch_stb(fetch_stb),
        .fetch_adr(fetch_adr), .fetch_ack(fetch_ack),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_ack(wb_ack),
        .rd_data(wb_dat_r),
        .ram_en(ram_en), .ram_we(ram_we), .ram_addr(ram_addr),
        .ram_wdata(ram_wdata), .ram_rdata(ram_rdata)
    );

    // one word per column and half-row
    framebuffer_ram #(
        .depth(`LED_PANEL_WIDTH * `LED_PANEL_HALF_HEIGHT)
    ) framebuffer_ram_inst (
        .clk_in(clk_in), .en(ram_en), .we(ram_we),
        .addr(ram_addr), .wdata(ram_wdata), .rdata(ram_rdata)
    );

    framebuffer_fetch framebuffer_fetch_inst (
        .clk_in(clk_in), .reset(reset),
        .col(col), .row(row_sel), .load_start(load_start),
        .fetch_cyc(fetch_cyc), .fetch_stb(fetch_stb),
        .fetch_adr(fetch_adr), .fetch_ack(fetch_ack),
        .rd_data(wb_dat_r),
        .pixel_top(pixel_top), .pixel_bottom(pixel_bottom),
        .load_done(load_done)
    );

    row_scanner row_scanner_inst (
        .clk_in(clk_in), .reset(reset),
        .col(col), .row_sel(row_sel), .load_start(load_start),
        .load_done(load_done),
        .pixel_top(pixel_top), .pixel_bottom(pixel_bottom),
        .rgb_top(rgb_top), .rgb_bottom(rgb_bottom),
        .panel_clk(panel_clk), .latch(latch), .blank(blank)
    );

endmodule

// File: testbench/tb_led_panel.sv
/*
 * testbench for the LED panel top level
 * host bus model, reference framebuffer, panel output checks and timeout
 */
`timescale 1ns/1ps
`include "led_panel_config.svh"

module tb_led_panel;

    localparam int fb_words = `LED_PANEL_WIDTH * `LED_PANEL_HALF_HEIGHT;
    // two frames of about 6000 cycles, host traffic, and margin
    localparam int cycle_limit = 40000;

    logic clk_in;
    logic reset;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    bus_types_pkg::fb_addr_t wb_adr;
    bus_types_pkg::fb_data_t wb_dat_w;
    bus_types_pkg::fb_data_t wb_dat_r;
    logic wb_ack;
    logic [2:0] rgb_top;
    logic [2:0] rgb_bottom;
    logic panel_clk;
    logic latch;
    logic blank;
    panel_types_pkg::row_addr_t row_sel;

    bus_types_pkg::fb_data_t ref_mem [fb_words];
    integer seed = 32'h8c65_3a53;
    int cycle_cnt = 0;
    int col_cnt = 0;
    int pixel_checks = 0;
    logic fill_done = 1'b0;
    logic pixel_check_en = 1'b0;
    logic row_pending = 1'b0;
    panel_types_pkg::row_addr_t next_row;

    led_panel_top led_panel_top_inst (
        .clk_in(clk_in), .reset(reset),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .rgb_top(rgb_top), .rgb_bottom(rgb_bottom),
        .panel_clk(panel_clk), .latch(latch), .blank(blank), .row_sel(row_sel)
    );

    initial begin
        clk_in = 1'b0;
        forever #10 clk_in = ~clk_in;
    end

    task automatic flag_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        $display("[FAIL] %0t ns %s expected %0h actual %0h", $time, name, expected, actual);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic abort_run(input string reason);
        $display("%0t ns %s", $time, reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // one classic cycle, inputs held until ack
    task automatic bus_cycle(input logic write, input bus_types_pkg::fb_addr_t adr,
                             input bus_types_pkg::fb_data_t wdata,
                             output bus_types_pkg::fb_data_t rdata);
        @(posedge clk_in);
        #2;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = write;
        wb_adr = adr;
        wb_dat_w = wdata;
        do begin
            @(posedge clk_in);
            #2;
        end while (!wb_ack);
        rdata = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        if (write) begin
            ref_mem[adr] = wdata;
        end
    endtask

    task automatic write_word(input bus_types_pkg::fb_addr_t adr,
                              input bus_types_pkg::fb_data_t data);
        bus_types_pkg::fb_data_t unused;
        bus_cycle(1'b1, adr, data, unused);
    endtask

    task automatic read_and_compare(input bus_types_pkg::fb_addr_t adr);
        bus_types_pkg::fb_data_t data;
        bus_cycle(1'b0, adr, '0, data);
        if (data !== ref_mem[adr]) begin
            flag_mismatch("wb_dat_r", ref_mem[adr], data);
        end
    endtask

    task automatic wait_for_latch;
        do begin
            @(posedge clk_in);
            #2;
        end while (!latch);
    endtask

    // msb of red, green and blue of each rgb565 half
    task automatic check_pixel(input bus_types_pkg::fb_data_t word);
        logic [2:0] exp_top;
        logic [2:0] exp_bottom;
        exp_top = {word[15], word[10], word[4]};
        exp_bottom = {word[31], word[26], word[20]};
        if (rgb_top !== exp_top) begin
            flag_mismatch("rgb_top", exp_top, rgb_top);
        end
        if (rgb_bottom !== exp_bottom) begin
            flag_mismatch("rgb_bottom", exp_bottom, rgb_bottom);
        end
        pixel_checks++;
    endtask

    always @(posedge clk_in) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == cycle_limit) begin
            $display("run did not finish within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    // reset cycles and the first cycle after reset
    reset_outputs: assert property (@(posedge clk_in) cycle_cnt inside {[1:17]} |->
        {panel_clk, latch, wb_ack, rgb_top, rgb_bottom, blank, row_sel} == 14'h0010)
        else flag_mismatch("{panel_clk, latch, wb_ack, rgb_top, rgb_bottom, blank, row_sel}",
            14'h0010, $sampled({panel_clk, latch, wb_ack, rgb_top, rgb_bottom, blank, row_sel}));

    latch_in_blank: assert property (@(posedge clk_in) disable iff (reset) latch |-> blank)
        else abort_run("latch pulsed while blank was low");

    host_ack_bound: assert property (@(posedge clk_in) disable iff (reset)
        $rose(wb_stb) |-> ##[1:4] wb_ack)
        else abort_run("host request not acknowledged within 4 cycles");

    // outputs are registered on the rising edge, so the falling edge sees them settled
    always @(negedge clk_in) begin
        if (!reset) begin
            if (latch) begin
                if (col_cnt != `LED_PANEL_WIDTH) begin
                    flag_mismatch("panel_clk pulses per row", `LED_PANEL_WIDTH, col_cnt);
                end
                col_cnt = 0;
                next_row = row_sel + 1'b1;
                row_pending = 1'b1;
                pixel_check_en = fill_done;
            end
            if (panel_clk) begin
                if (row_pending && row_sel !== next_row) begin
                    flag_mismatch("row_sel", next_row, row_sel);
                end
                row_pending = 1'b0;
                if (col_cnt >= `LED_PANEL_WIDTH) begin
                    abort_run("more panel_clk pulses than columns before latch");
                end
                if (pixel_check_en) begin
                    check_pixel(ref_mem[{row_sel, col_cnt[5:0]}]);
                end
                col_cnt++;
            end
        end
    end

    initial begin
        panel_types_pkg::row_addr_t far_row;
        logic [5:0] col;
        int gap;
        reset = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        repeat (16) @(posedge clk_in);
        #2;
        reset = 1'b0;

        // whole framebuffer, written while the scanner already runs
        for (int a = 0; a < fb_words; a++) begin
            write_word(a[9:0], $random(seed));
        end
        fill_done = 1'b1;
        wait_for_latch();

        repeat (64) begin
            read_and_compare(bus_types_pkg::fb_addr_t'($random(seed)));
        end

        // random gaps move host requests against the fetch phase
        // target row stays half a frame away from the row on display
        repeat (200) begin
            gap = $random(seed) & 3;
            repeat (gap) @(posedge clk_in);
            far_row = row_sel + 4'd8;
            col = $random(seed);
            write_word({far_row, col}, $random(seed));
        end

        // new content for one row, then a full frame of rows to show it
        far_row = row_sel + 4'd8;
        for (int c = 0; c < `LED_PANEL_WIDTH; c++) begin
            write_word({far_row, c[5:0]}, $random(seed));
        end
        repeat (`LED_PANEL_HALF_HEIGHT + 1) wait_for_latch();
        for (int c = 0; c < `LED_PANEL_WIDTH; c++) begin
            read_and_compare({far_row, c[5:0]});
        end

        if (pixel_checks < fb_words) begin
            $display("only %0d pixels were checked, less than one frame", pixel_checks);
            $display("Simulation failed");
            $fatal(1);
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

// File: filelist.f
+incdir+src
src/panel_types_pkg.sv
src/bus_types_pkg.sv
src/framebuffer_ram.sv
src/fb_arbiter.sv
src/framebuffer_fetch.sv
src/row_scanner.sv
src/led_panel_top.sv
testbench/tb_led_panel.sv

// File: Bender.yml
package:
  name: led_panel

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/panel_types_pkg.sv
      - src/bus_types_pkg.sv
      - src/framebuffer_ram.sv
      - src/fb_arbiter.sv
      - src/framebuffer_fetch.sv
      - src/row_scanner.sv
      - src/led_panel_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - testbench/tb_led_panel.sv
